/* hdl/pwr_mgr_consts.svh */
////////////////////
// wakeup count, axi widths and register offsets
////////////////////
`ifndef PWR_MGR_CONSTS_SVH
`define PWR_MGR_CONSTS_SVH

// number of wakeup sources
`define PWR_NUM_WAKE 4

// axi4-lite bus widths
`define PWR_AXI_AW 4
`define PWR_AXI_DW 32

// register map, word aligned
`define PWR_REG_CTRL    4'h0
`define PWR_REG_WAKE_EN 4'h4
`define PWR_REG_WAKE_ST 4'h8
`define PWR_REG_STATUS  4'hC

`endif

/* hdl/pwr_mgr_pkg.sv */
////////////////////
// fsm state and power-up cause types
////////////////////
package pwr_mgr_pkg;

  // slow fsm, always-on sequencing
  typedef enum logic [3:0] {
    SlowReset        = 4'd0,
    SlowMainPowerOn  = 4'd1,
    SlowClampOff     = 4'd2,
    SlowClocksOn     = 4'd3,
    SlowReqPwrUp     = 4'd4,
    SlowIdle         = 4'd5,
    SlowAckPwrDn     = 4'd6,
    SlowClocksOff    = 4'd7,
    SlowClampOn      = 4'd8,
    SlowMainPowerOff = 4'd9,
    SlowLowPower     = 4'd10
  } slow_state_e;

  // fast fsm, core reset and low-power entry
  typedef enum logic [1:0] {
    FastLowPower = 2'd0,
    FastActive   = 2'd1,
    FastReqPwrDn = 2'd2
  } fast_state_e;

  // why the domain was last powered up
  typedef enum logic [1:0] {
    Por   = 2'd0,
    Wake  = 2'd1,
    Reset = 2'd2
  } pwrup_cause_e;

endpackage

/* hdl/pwr_mgr_reg_pkg.sv */
////////////////////
// register select and axi response types
////////////////////
package pwr_mgr_reg_pkg;

  // decoded register targets
  typedef enum logic [2:0] {
    RegCtrl   = 3'd0,
    RegWakeEn = 3'd1,
    RegWakeSt = 3'd2,
    RegStatus = 3'd3,
    RegNone   = 3'd4
  } reg_sel_e;

  // axi4-lite response codes in use
  typedef enum logic [1:0] {
    Okay   = 2'b00,
    SlvErr = 2'b10
  } axi_resp_e;

endpackage

/* hdl/pwr_mgr_regs.sv */
////////////////////
// axi4-lite slave with control, wakeup and status registers
////////////////////
`timescale 1ns/1ps
`include "pwr_mgr_consts.svh"

module pwr_mgr_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // axi4-lite write channels
  input  logic [`PWR_AXI_AW-1:0]     awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [`PWR_AXI_DW-1:0]     wdata_i,
  input  logic [`PWR_AXI_DW/8-1:0]   wstrb_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output pwr_mgr_reg_pkg::axi_resp_e bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  // axi4-lite read channels
  input  logic [`PWR_AXI_AW-1:0]     araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic [`PWR_AXI_DW-1:0]     rdata_o,
  output pwr_mgr_reg_pkg::axi_resp_e rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  // hardware side
  input  logic                       lp_entered_i,
  input  logic [`PWR_NUM_WAKE-1:0]   wake_st_i,
  input  pwr_mgr_pkg::pwrup_cause_e  pwrup_cause_i,
  input  logic                       rst_req_i,
  input  logic                       fsm_invalid_i,
  output logic                       lp_hint_o,
  output logic                       main_pd_n_o,
  output logic                       core_clk_lp_o,
  output logic                       io_clk_lp_o,
  output logic [`PWR_NUM_WAKE-1:0]   wake_en_o,
  output logic [`PWR_NUM_WAKE-1:0]   wake_clr_o,
  output logic                       clr_req_o
);
  import pwr_mgr_reg_pkg::*;

  // pending write, held while bvalid is up
  reg_sel_e               wr_sel_q;
  logic [`PWR_AXI_DW-1:0] wr_data_q;
  logic                   wr_be_q;
  logic                   bvalid_q;
  axi_resp_e              bresp_q;
  // read response
  logic                   rvalid_q;
  axi_resp_e              rresp_q;
  logic [`PWR_AXI_DW-1:0] rdata_q;
  logic [`PWR_AXI_DW-1:0] rdata_d;
  reg_sel_e               wr_sel;
  reg_sel_e               rd_sel;
  // register state
  logic [3:0]             ctrl_q;
  logic [`PWR_NUM_WAKE-1:0] wake_en_q;
  logic                   wr_accept;
  logic                   rd_accept;
  logic                   b_fire;
  logic                   wr_commit;

  function automatic reg_sel_e decode(input logic [`PWR_AXI_AW-1:0] addr);
    case (addr)
      `PWR_REG_CTRL:    return RegCtrl;
      `PWR_REG_WAKE_EN: return RegWakeEn;
      `PWR_REG_WAKE_ST: return RegWakeSt;
      `PWR_REG_STATUS:  return RegStatus;
      default:          return RegNone;
    endcase
  endfunction

  ////////////////////
  // handshakes
  ////////////////////

  // aw and w taken together, only with no response outstanding
  assign wr_accept = awvalid_i & wvalid_i & ~bvalid_q;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign rd_accept = arvalid_i & ~rvalid_q;
  assign arready_o = rd_accept;

  assign b_fire    = bvalid_q & bready_i;
  // registers update on the b handshake, only byte 0 holds fields
  assign wr_commit = b_fire & wr_be_q;

  assign wr_sel = decode(awaddr_i);
  assign rd_sel = decode(araddr_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      bresp_q  <= Okay;
      rvalid_q <= 1'b0;
      rresp_q  <= Okay;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
        bresp_q  <= (wr_sel == RegNone) ? SlvErr : Okay;
      end else if (b_fire) begin
        bvalid_q <= 1'b0;
      end
      if (rd_accept) begin
        rvalid_q <= 1'b1;
        rresp_q  <= (rd_sel == RegNone) ? SlvErr : Okay;
      end else if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // payload capture
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      wr_sel_q  <= wr_sel;
      wr_data_q <= wdata_i;
      wr_be_q   <= wstrb_i[0];
    end
    if (rd_accept) begin
      rdata_q <= rdata_d;
    end
  end

  ////////////////////
  // register state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // main_pd_n set, everything else clear
      ctrl_q    <= 4'h2;
      wake_en_q <= '0;
    end else begin
      if (wr_commit && wr_sel_q == RegCtrl) begin
        ctrl_q <= wr_data_q[3:0];
      end
      // fast fsm consumed the hint
      if (lp_entered_i) begin
        ctrl_q[0] <= 1'b0;
      end
      if (wr_commit && wr_sel_q == RegWakeEn) begin
        wake_en_q <= wr_data_q[`PWR_NUM_WAKE-1:0];
      end
    end
  end

  // write-one-to-clear pulses
  assign wake_clr_o = (wr_commit && wr_sel_q == RegWakeSt) ?
                      wr_data_q[`PWR_NUM_WAKE-1:0] : '0;
  assign clr_req_o  = wr_commit & (wr_sel_q == RegStatus) & wr_data_q[0];

  // read mux, unmapped reads as zero
  always_comb begin
    rdata_d = '0;
    case (rd_sel)
      RegCtrl:   rdata_d[3:0] = ctrl_q;
      RegWakeEn: rdata_d[`PWR_NUM_WAKE-1:0] = wake_en_q;
      RegWakeSt: rdata_d[`PWR_NUM_WAKE-1:0] = wake_st_i;
      RegStatus: begin
        rdata_d[0]   = rst_req_i;
        rdata_d[1]   = fsm_invalid_i;
        rdata_d[5:4] = pwrup_cause_i;
      end
      default:   rdata_d = '0;
    endcase
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

  assign lp_hint_o     = ctrl_q[0];
  assign main_pd_n_o   = ctrl_q[1];
  assign core_clk_lp_o = ctrl_q[2];
  assign io_clk_lp_o   = ctrl_q[3];
  assign wake_en_o     = wake_en_q;

endmodule

/* hdl/pwr_wake_detect.sv */
////////////////////
// one wakeup source detector
////////////////////
`timescale 1ns/1ps

module pwr_wake_detect (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wake_req_i,
  input  logic en_i,
  input  logic clr_i,
  output logic wake_lvl_o,
  output logic wake_st_o
);

  logic [1:0] sync_q;
  logic       st_q;

  // two-flop synchronizer for the async request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], wake_req_i};
    end
  end

  // only enabled sources count
  assign wake_lvl_o = sync_q[1] & en_i;

  // sticky status, set beats clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= 1'b0;
    end else if (wake_lvl_o) begin
      st_q <= 1'b1;
    end else if (clr_i) begin
      st_q <= 1'b0;
    end
  end

  assign wake_st_o = st_q;

endmodule

/* hdl/pwr_slow_fsm.sv */
////////////////////
// slow fsm for power sequencing and power-good monitor
////////////////////
`timescale 1ns/1ps
`include "pwr_mgr_consts.svh"

module pwr_slow_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`PWR_NUM_WAKE-1:0]  wake_lvl_i,
  // low-power configuration
  input  logic                      main_pd_n_i,
  input  logic                      core_clk_lp_i,
  input  logic                      io_clk_lp_i,
  input  logic                      clr_req_i,
  // analog feedback
  input  logic                      main_pok_i,
  input  logic                      core_clk_val_i,
  input  logic                      io_clk_val_i,
  // fast fsm handshakes
  input  logic                      ack_pwrup_i,
  input  logic                      req_pwrdn_i,
  output logic                      req_pwrup_o,
  output logic                      ack_pwrdn_o,
  // status
  output pwr_mgr_pkg::pwrup_cause_e pwrup_cause_o,
  output logic                      rst_req_o,
  output logic                      fsm_invalid_o,
  // analog controls
  output logic                      main_pd_no,
  output logic                      pwr_clamp_o,
  output logic                      core_clk_en_o,
  output logic                      io_clk_en_o
);
  import pwr_mgr_pkg::*;

  slow_state_e  state_q, state_d;
  pwrup_cause_e cause_q, cause_d;
  logic         req_pwrup_q, req_pwrup_d;
  logic         ack_pwrdn_q, ack_pwrdn_d;
  // analog controls are all flopped, no glitches toward the domain
  logic         pd_nq, pd_nd;
  logic         clamp_q, clamp_d;
  logic         core_en_q, io_en_q;
  logic         fsm_invalid_q, fsm_invalid_d;
  logic         clk_active;
  logic         core_en_lp, io_en_lp;
  logic         all_clks_valid, all_clks_invalid;
  logic         wakeup;
  // power-good capture and monitor
  logic [2:0]   pok_q;
  logic         main_pok_st;
  logic         set_mon;
  logic         mon_q;
  logic         rst_req_q;

  assign wakeup = |wake_lvl_i;

  // low-power clock state, forced off when power is cut
  assign core_en_lp = main_pd_n_i & core_clk_lp_i;
  assign io_en_lp   = main_pd_n_i & io_clk_lp_i;

  assign all_clks_valid   = core_clk_val_i & io_clk_val_i;
  // clocks meant to stop must read invalid, others bypass
  assign all_clks_invalid = (core_en_lp | ~core_clk_val_i) & (io_en_lp | ~io_clk_val_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= SlowReset;
      cause_q       <= Por;
      req_pwrup_q   <= 1'b0;
      ack_pwrdn_q   <= 1'b0;
      pd_nq         <= 1'b1;
      clamp_q       <= 1'b1;
      core_en_q     <= 1'b0;
      io_en_q       <= 1'b0;
      fsm_invalid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      cause_q       <= cause_d;
      req_pwrup_q   <= req_pwrup_d;
      ack_pwrdn_q   <= ack_pwrdn_d;
      pd_nq         <= pd_nd;
      clamp_q       <= clamp_d;
      // invalid fsm keeps clocks running so the core can be reset
      core_en_q     <= fsm_invalid_q | clk_active | core_en_lp;
      io_en_q       <= fsm_invalid_q | clk_active | io_en_lp;
      fsm_invalid_q <= fsm_invalid_d;
    end
  end

  ////////////////////
  // sequencing
  ////////////////////

  always_comb begin
    state_d       = state_q;
    cause_d       = cause_q;
    req_pwrup_d   = req_pwrup_q;
    ack_pwrdn_d   = ack_pwrdn_q;
    pd_nd         = pd_nq;
    clamp_d       = clamp_q;
    fsm_invalid_d = fsm_invalid_q;
    clk_active    = 1'b0;
    set_mon       = 1'b0;

    case (state_q)
      SlowReset: begin
        cause_d = Por;
        state_d = SlowMainPowerOn;
      end
      SlowLowPower: begin
        // a pending reset request powers up like a wakeup
        if (wakeup || rst_req_q) begin
          cause_d = rst_req_q ? Reset : Wake;
          state_d = SlowMainPowerOn;
        end
      end
      SlowMainPowerOn: begin
        pd_nd = 1'b1;
        if (main_pok_st) begin
          set_mon = 1'b1;
          state_d = SlowClampOff;
        end
      end
      SlowClampOff: begin
        clamp_d = 1'b0;
        state_d = SlowClocksOn;
      end
      SlowClocksOn: begin
        clk_active = 1'b1;
        if (all_clks_valid) begin
          state_d = SlowReqPwrUp;
        end
      end
      SlowReqPwrUp: begin
        clk_active  = 1'b1;
        req_pwrup_d = 1'b1;
        // previous power-down round must be fully closed
        if (ack_pwrup_i && !req_pwrdn_i) begin
          req_pwrup_d = 1'b0;
          state_d     = SlowIdle;
        end
      end
      SlowIdle: begin
        clk_active = 1'b1;
        if (req_pwrdn_i && !ack_pwrup_i) begin
          state_d = SlowAckPwrDn;
        end
      end
      SlowAckPwrDn: begin
        clk_active  = 1'b1;
        ack_pwrdn_d = 1'b1;
        if (!req_pwrdn_i) begin
          ack_pwrdn_d = 1'b0;
          state_d     = SlowClocksOff;
        end
      end
      SlowClocksOff: begin
        if (all_clks_invalid) begin
          state_d = SlowClampOn;
        end
      end
      SlowClampOn: begin
        // clamp only if power is going away
        clamp_d = ~main_pd_n_i;
        state_d = SlowMainPowerOff;
      end
      SlowMainPowerOff: begin
        pd_nd = main_pd_n_i;
        // done once power is gone, or when it was meant to stay
        if (!main_pok_st || main_pd_n_i) begin
          state_d = SlowLowPower;
        end
      end
      default: begin
        // unreachable encoding, cut power behind the clamp
        fsm_invalid_d = 1'b1;
        pd_nd         = 1'b0;
        clamp_d       = 1'b1;
      end
    endcase
  end

  ////////////////////
  // power-good monitor
  ////////////////////

  // capture flop then two-flop synchronizer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pok_q <= '0;
    end else begin
      pok_q <= {pok_q[1:0], main_pok_i};
    end
  end

  assign main_pok_st = pok_q[2];

  // armed at power-on, disarmed once power-down is intended
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mon_q <= 1'b0;
    end else if (!pd_nd && mon_q) begin
      mon_q <= 1'b0;
    end else if (set_mon) begin
      mon_q <= 1'b1;
    end
  end

  // sticky until software clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_req_q <= 1'b0;
    end else if (clr_req_i) begin
      rst_req_q <= 1'b0;
    end else if (mon_q && !main_pok_st) begin
      rst_req_q <= 1'b1;
    end
  end

  assign req_pwrup_o   = req_pwrup_q;
  assign ack_pwrdn_o   = ack_pwrdn_q;
  assign pwrup_cause_o = cause_q;
  assign rst_req_o     = rst_req_q;
  assign fsm_invalid_o = fsm_invalid_q;
  assign main_pd_no    = pd_nq;
  assign pwr_clamp_o   = clamp_q;
  assign core_clk_en_o = core_en_q;
  assign io_clk_en_o   = io_en_q;

endmodule

/* hdl/pwr_fast_fsm.sv */
////////////////////
// fast fsm for core reset and low-power entry
////////////////////
`timescale 1ns/1ps

module pwr_fast_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_pwrup_i,
  input  logic ack_pwrdn_i,
  input  logic lp_hint_i,
  input  logic cpu_sleep_i,
  input  logic rst_req_i,
  output logic ack_pwrup_o,
  output logic req_pwrdn_o,
  output logic lp_entered_o,
  output logic rst_core_no
);
  import pwr_mgr_pkg::*;

  fast_state_e state_q, state_d;
  logic        ack_pwrup_q, ack_pwrup_d;
  logic        req_pwrdn_q, req_pwrdn_d;
  logic        rst_core_nq, rst_core_nd;
  logic        lp_enter;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FastLowPower;
      ack_pwrup_q <= 1'b0;
      req_pwrdn_q <= 1'b0;
      rst_core_nq <= 1'b0;
    end else begin
      state_q     <= state_d;
      ack_pwrup_q <= ack_pwrup_d;
      req_pwrdn_q <= req_pwrdn_d;
      rst_core_nq <= rst_core_nd;
    end
  end

  always_comb begin
    state_d     = state_q;
    ack_pwrup_d = ack_pwrup_q;
    req_pwrdn_d = req_pwrdn_q;
    // core held in reset unless active and settled
    rst_core_nd = 1'b0;
    lp_enter    = 1'b0;

    case (state_q)
      FastLowPower: begin
        if (req_pwrup_i) begin
          ack_pwrup_d = 1'b1;
          state_d     = FastActive;
        end
      end
      FastActive: begin
        if (ack_pwrup_q) begin
          // close the power-up handshake first
          if (!req_pwrup_i) begin
            ack_pwrup_d = 1'b0;
          end
        end else if (lp_hint_i && cpu_sleep_i) begin
          lp_enter    = 1'b1;
          req_pwrdn_d = 1'b1;
          state_d     = FastReqPwrDn;
        end else begin
          // power loss keeps the core in reset
          rst_core_nd = ~rst_req_i;
        end
      end
      FastReqPwrDn: begin
        if (ack_pwrdn_i) begin
          req_pwrdn_d = 1'b0;
          state_d     = FastLowPower;
        end
      end
      default: begin
        state_d = FastLowPower;
      end
    endcase
  end

  assign ack_pwrup_o  = ack_pwrup_q;
  assign req_pwrdn_o  = req_pwrdn_q;
  assign lp_entered_o = lp_enter;
  assign rst_core_no  = rst_core_nq;

endmodule

/* hdl/pwr_mgr.sv */
////////////////////
// power manager top, registers, detectors and both fsms
////////////////////
`timescale 1ns/1ps
`include "pwr_mgr_consts.svh"

module pwr_mgr (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // axi4-lite slave
  input  logic [`PWR_AXI_AW-1:0]     awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [`PWR_AXI_DW-1:0]     wdata_i,
  input  logic [`PWR_AXI_DW/8-1:0]   wstrb_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output pwr_mgr_reg_pkg::axi_resp_e bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  input  logic [`PWR_AXI_AW-1:0]     araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic [`PWR_AXI_DW-1:0]     rdata_o,
  output pwr_mgr_reg_pkg::axi_resp_e rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  // system inputs
  input  logic [`PWR_NUM_WAKE-1:0]   wake_req_i,
  input  logic                       cpu_sleep_i,
  input  logic                       main_pok_i,
  input  logic                       core_clk_val_i,
  input  logic                       io_clk_val_i,
  // analog and reset controls
  output logic                       main_pd_no,
  output logic                       pwr_clamp_o,
  output logic                       core_clk_en_o,
  output logic                       io_clk_en_o,
  output logic                       rst_core_no
);
  import pwr_mgr_pkg::*;

  logic [`PWR_NUM_WAKE-1:0] wake_en, wake_clr, wake_st, wake_lvl;
  logic         lp_hint, lp_entered;
  logic         main_pd_n, core_clk_lp, io_clk_lp;
  logic         clr_req, rst_req, fsm_invalid;
  pwrup_cause_e pwrup_cause;
  // fsm handshakes
  logic         req_pwrup, ack_pwrup, req_pwrdn, ack_pwrdn;

  pwr_mgr_regs u_regs (
    .clk_i,
    .rst_ni,
    .awaddr_i,
    .awvalid_i,
    .awready_o,
    .wdata_i,
    .wstrb_i,
    .wvalid_i,
    .wready_o,
    .bresp_o,
    .bvalid_o,
    .bready_i,
    .araddr_i,
    .arvalid_i,
    .arready_o,
    .rdata_o,
    .rresp_o,
    .rvalid_o,
    .rready_i,
    .lp_entered_i  (lp_entered),
    .wake_st_i     (wake_st),
    .pwrup_cause_i (pwrup_cause),
    .rst_req_i     (rst_req),
    .fsm_invalid_i (fsm_invalid),
    .lp_hint_o     (lp_hint),
    .main_pd_n_o   (main_pd_n),
    .core_clk_lp_o (core_clk_lp),
    .io_clk_lp_o   (io_clk_lp),
    .wake_en_o     (wake_en),
    .wake_clr_o    (wake_clr),
    .clr_req_o     (clr_req)
  );

  // one detector per wakeup source
  for (genvar i = 0; i < `PWR_NUM_WAKE; i++) begin : g_wake
    pwr_wake_detect u_wake (
      .clk_i,
      .rst_ni,
      .wake_req_i (wake_req_i[i]),
      .en_i       (wake_en[i]),
      .clr_i      (wake_clr[i]),
      .wake_lvl_o (wake_lvl[i]),
      .wake_st_o  (wake_st[i])
    );
  end

  pwr_slow_fsm u_slow_fsm (
    .clk_i,
    .rst_ni,
    .wake_lvl_i    (wake_lvl),
    .main_pd_n_i   (main_pd_n),
    .core_clk_lp_i (core_clk_lp),
    .io_clk_lp_i   (io_clk_lp),
    .clr_req_i     (clr_req),
    .main_pok_i,
    .core_clk_val_i,
    .io_clk_val_i,
    .ack_pwrup_i   (ack_pwrup),
    .req_pwrdn_i   (req_pwrdn),
    .req_pwrup_o   (req_pwrup),
    .ack_pwrdn_o   (ack_pwrdn),
    .pwrup_cause_o (pwrup_cause),
    .rst_req_o     (rst_req),
    .fsm_invalid_o (fsm_invalid),
    .main_pd_no,
    .pwr_clamp_o,
    .core_clk_en_o,
    .io_clk_en_o
  );

  pwr_fast_fsm u_fast_fsm (
    .clk_i,
    .rst_ni,
    .req_pwrup_i  (req_pwrup),
    .ack_pwrdn_i  (ack_pwrdn),
    .lp_hint_i    (lp_hint),
    .cpu_sleep_i,
    .rst_req_i    (rst_req),
    .ack_pwrup_o  (ack_pwrup),
    .req_pwrdn_o  (req_pwrdn),
    .lp_entered_o (lp_entered),
    .rst_core_no
  );

endmodule

/* tb/pwr_mgr_properties.sv */
////////////////////
// handshake and sequencing assertions bound into both fsms
////////////////////
`timescale 1ns/1ps

module pwr_mgr_properties #(
  // only the slow fsm drives the supply and the clamp
  parameter bit CheckClamp = 1'b1
) (
  input logic clk_i,
  input logic rst_ni,
  input logic req_pwrup_i,
  input logic ack_pwrup_i,
  input logic req_pwrdn_i,
  input logic ack_pwrdn_i,
  input logic main_pd_n_i,
  input logic pwr_clamp_i
);

  // power-up request and power-down ack belong to different phases
  a_no_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_pwrup_i && ack_pwrdn_i))
    else $error("power-up request and power-down ack high together");

  // domain is isolated whenever its supply is off
  if (CheckClamp) begin : g_clamp
    a_clamp_on: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !main_pd_n_i |-> pwr_clamp_i)
      else $error("main power off without clamp");
  end

  // four-phase handshake where ack drops only after request dropped
  a_pwrup_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(ack_pwrup_i) |-> !req_pwrup_i)
    else $error("power-up ack fell while request high");

  a_pwrdn_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(ack_pwrdn_i) |-> !req_pwrdn_i)
    else $error("power-down ack fell while request high");

endmodule

bind pwr_slow_fsm pwr_mgr_properties u_slow_props (
  .clk_i(clk_i), .rst_ni(rst_ni),
  .req_pwrup_i(req_pwrup_o), .ack_pwrup_i(ack_pwrup_i),
  .req_pwrdn_i(req_pwrdn_i), .ack_pwrdn_i(ack_pwrdn_o),
  .main_pd_n_i(main_pd_no), .pwr_clamp_i(pwr_clamp_o)
);

bind pwr_fast_fsm pwr_mgr_properties #(.CheckClamp(1'b0)) u_fast_props (
  .clk_i(clk_i), .rst_ni(rst_ni),
  .req_pwrup_i(req_pwrup_i), .ack_pwrup_i(ack_pwrup_o),
  .req_pwrdn_i(req_pwrdn_o), .ack_pwrdn_i(ack_pwrdn_i),
  .main_pd_n_i(1'b1), .pwr_clamp_i(1'b1)
);

/* tb/pwr_mgr_tb.sv */
////////////////////
// power manager testbench, axi tasks, analog model and checker
////////////////////
`timescale 1ns/1ps
`include "pwr_mgr_consts.svh"

module pwr_mgr_tb;
  import pwr_mgr_reg_pkg::*;

  localparam int MaxCycles = 20000;
  localparam int WaitLimit = 600;

  logic        clk_i, rst_ni;
  logic [3:0]  awaddr_i, araddr_i;
  logic        awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  logic [31:0] wdata_i;
  logic [3:0]  wstrb_i;
  logic        awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  logic [1:0]  bresp_o, rresp_o;
  logic [31:0] rdata_o;
  logic [3:0]  wake_req_i;
  logic        cpu_sleep_i, main_pok_i, core_clk_val_i, io_clk_val_i;
  logic        main_pd_no, pwr_clamp_o, core_clk_en_o, io_clk_en_o, rst_core_no;

  // analog model state
  logic [2:0]  core_sr, io_sr;
  logic [3:0]  pd_sr;
  logic        pok_drop;

  int          errors;
  int          cycles;
  // pending comparisons drained by the compare process
  string       name_q[$];
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];
  string       chk_name;
  logic [31:0] chk_got, chk_exp;

  pwr_mgr dut (.*);

  always #50 clk_i = ~clk_i;

  ////////////////////
  // analog model
  ////////////////////
  always @(posedge clk_i) begin
    #1;
    core_sr        = {core_sr[1:0], core_clk_en_o};
    io_sr          = {io_sr[1:0], io_clk_en_o};
    pd_sr          = {pd_sr[2:0], main_pd_no};
    core_clk_val_i = core_sr[2];
    io_clk_val_i   = io_sr[2];
    main_pok_i     = pd_sr[3] & ~pok_drop;
  end

  // run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("%0t: run stopped, cycle limit of %0d reached", $time, MaxCycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // compare process
  always @(negedge clk_i) begin
    while (name_q.size() > 0) begin
      chk_name = name_q.pop_front();
      chk_got  = got_q.pop_front();
      chk_exp  = exp_q.pop_front();
      assert (chk_got === chk_exp) else begin
        errors++;
        $display("CHECK FAILED t=%0t %s got %h expected %h", $time, chk_name, chk_got,
                 chk_exp);
      end
    end
  end

  task automatic expect_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  // low-power outputs {main_pd_no, core_clk_en_o, io_clk_en_o}
  function automatic logic [2:0] expected_lp(input logic [3:0] ctrl);
    logic pd;
    pd = ctrl[1];
    return {pd, pd & ctrl[2], pd & ctrl[3]};
  endfunction

  // sticky bits only for enabled sources that pulsed
  function automatic logic [3:0] expected_wake_st(input logic [3:0] mask, input logic [3:0] en);
    return mask & en;
  endfunction

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = 4'hF;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    bready_i  = 1'b1;
    do @(negedge clk_i); while (!awready_o);
    @(posedge clk_i);
    #1;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    do @(negedge clk_i); while (!bvalid_o);
    resp = bresp_o;
    @(posedge clk_i);
    #1;
    bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    rready_i  = 1'b1;
    do @(negedge clk_i); while (!arready_o);
    @(posedge clk_i);
    #1;
    arvalid_i = 1'b0;
    do @(negedge clk_i); while (!rvalid_o);
    data = rdata_o;
    resp = rresp_o;
    @(posedge clk_i);
    #1;
    rready_i = 1'b0;
  endtask

  task automatic wait_core_rst(input logic level, input string what);
    int n;
    n = 0;
    while (rst_core_no !== level && n < WaitLimit) begin
      step(1);
      n++;
    end
    if (rst_core_no !== level) begin
      errors++;
      $display("%0t: %s, core reset never went to %0b", $time, what, level);
    end
  endtask

  task automatic wait_pd(input logic level);
    int n;
    n = 0;
    while (main_pd_no !== level && n < WaitLimit) begin
      step(1);
      n++;
    end
    if (main_pd_no !== level) begin
      errors++;
      $display("%0t: main power enable never settled to %0b", $time, level);
    end
  endtask

  task automatic pulse_wake(input logic [3:0] mask);
    wake_req_i = mask;
    step(3);
    wake_req_i = '0;
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    logic [3:0]  cfg, en, miss, hit;
    logic [2:0]  lp_exp;
    clk_i = 0;
    rst_ni = 0;
    awaddr_i = '0;
    araddr_i = '0;
    wdata_i = '0;
    wstrb_i = '0;
    awvalid_i = 0;
    wvalid_i = 0;
    bready_i = 0;
    arvalid_i = 0;
    rready_i = 0;
    wake_req_i = '0;
    cpu_sleep_i = 0;
    main_pok_i = 0;
    core_clk_val_i = 0;
    io_clk_val_i = 0;
    core_sr = '0;
    io_sr = '0;
    pd_sr = '0;
    pok_drop = 0;
    errors = 0;
    cycles = 0;
    void'($urandom(32'h4ad9f4fd));
    step(16);
    rst_ni = 1;

    //////////////////// power-on
    wait_core_rst(1'b1, "power-on");
    step(1);
    expect_eq("main_pd_no", 32'(main_pd_no), 32'd1);
    expect_eq("pwr_clamp_o", 32'(pwr_clamp_o), 32'd0);
    expect_eq("core_clk_en_o", 32'(core_clk_en_o), 32'd1);
    expect_eq("io_clk_en_o", 32'(io_clk_en_o), 32'd1);
    axi_read(`PWR_REG_STATUS, data, resp);
    expect_eq("status.cause", 32'(data[5:4]), 32'd0);

    //////////////////// register access
    repeat (4) begin
      en = 4'($urandom());
      axi_write(`PWR_REG_WAKE_EN, 32'(en), resp);
      expect_eq("bresp wake_en", 32'(resp), 32'(Okay));
      axi_read(`PWR_REG_WAKE_EN, data, resp);
      expect_eq("rresp wake_en", 32'(resp), 32'(Okay));
      expect_eq("wake_en", data, 32'(en));
    end
    axi_write(`PWR_REG_CTRL, 32'hE, resp);
    axi_read(`PWR_REG_CTRL, data, resp);
    expect_eq("ctrl", data, 32'hE);
    axi_write(4'h1, 32'hFFFF_FFFF, resp);
    expect_eq("bresp unmapped", 32'(resp), 32'(SlvErr));
    axi_read(4'h1, data, resp);
    expect_eq("rresp unmapped", 32'(resp), 32'(SlvErr));
    expect_eq("rdata unmapped", data, 32'd0);

    //////////////////// low-power entry and wakeup rounds
    repeat (5) begin
      cfg = {3'($urandom()), 1'b1};
      lp_exp = expected_lp(cfg);
      axi_write(`PWR_REG_CTRL, 32'(cfg), resp);
      cpu_sleep_i = 1'b1;
      wait_core_rst(1'b0, "low-power entry");
      cpu_sleep_i = 1'b0;
      wait_pd(lp_exp[2]);
      step(20);
      expect_eq("main_pd_no", 32'(main_pd_no), 32'(lp_exp[2]));
      expect_eq("core_clk_en_o", 32'(core_clk_en_o), 32'(lp_exp[1]));
      expect_eq("io_clk_en_o", 32'(io_clk_en_o), 32'(lp_exp[0]));
      axi_read(`PWR_REG_CTRL, data, resp);
      expect_eq("ctrl.hint", 32'(data[0]), 32'd0);

      en = 4'($urandom());
      if (en == 0) en = 4'h1;
      axi_write(`PWR_REG_WAKE_EN, 32'(en), resp);
      // disabled sources alone must not wake
      miss = ~en;
      if (miss != 0) begin
        pulse_wake(miss);
        step(30);
        expect_eq("rst_core_no asleep", 32'(rst_core_no), 32'd0);
      end
      hit = 4'($urandom()) | (en & (~en + 4'd1));
      pulse_wake(hit);
      wait_core_rst(1'b1, "wakeup");
      axi_read(`PWR_REG_STATUS, data, resp);
      expect_eq("status.cause", 32'(data[5:4]), 32'd1);
      axi_read(`PWR_REG_WAKE_ST, data, resp);
      expect_eq("wake_st", data, 32'(expected_wake_st(hit, en)));
      axi_write(`PWR_REG_WAKE_ST, 32'hF, resp);
      axi_read(`PWR_REG_WAKE_ST, data, resp);
      expect_eq("wake_st cleared", data, 32'd0);
    end

    //////////////////// power loss while active
    pok_drop = 1'b1;
    wait_core_rst(1'b0, "power loss");
    step(2);
    axi_read(`PWR_REG_STATUS, data, resp);
    expect_eq("status.rst_req", 32'(data[0]), 32'd1);
    expect_eq("rst_core_no", 32'(rst_core_no), 32'd0);
    pok_drop = 1'b0;
    step(10);
    axi_write(`PWR_REG_STATUS, 32'h1, resp);
    axi_read(`PWR_REG_STATUS, data, resp);
    expect_eq("status.rst_req cleared", 32'(data[0]), 32'd0);
    wait_core_rst(1'b1, "power restored");

    step(3);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* pwr_mgr.f */
+incdir+hdl
hdl/pwr_mgr_pkg.sv
hdl/pwr_mgr_reg_pkg.sv
hdl/pwr_mgr_regs.sv
hdl/pwr_wake_detect.sv
hdl/pwr_slow_fsm.sv
hdl/pwr_fast_fsm.sv
hdl/pwr_mgr.sv
tb/pwr_mgr_properties.sv
tb/pwr_mgr_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the power manager testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f pwr_mgr.f --top-module pwr_mgr_tb \
  -o Vpwr_mgr_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/Vpwr_mgr_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1
